//--- design/butterfly_enable_delay.sv
`include "ntt_config.svh"

module butterfly_enable_delay (
  input  logic clk,
  input  logic rst,
  input  logic read_active,
  input  logic sel_radix4,
  input  logic draining,
  output logic wen,
  output logic en
);

  // per line taps, index 0 is read_active one cycle late
  localparam int R2_WEN_TAP = `NTT_R2_WEN_DELAY - 1;
  localparam int R4_WEN_TAP = `NTT_R4_WEN_DELAY - 1;
  // en_direct plus the drain count
  localparam int R2_EN_TAP  = `NTT_R2_DRAIN;
  localparam int R4_EN_TAP  = `NTT_R4_DRAIN;

  // tap outputs, bit 0 radix-2 and bit 1 radix-4
  logic [1:0] line_wen;
  logic [1:0] line_en;
  // unit enable while running
  logic       en_direct;

  // one history line per radix
  // each shifts only while its radix is selected
  for (genvar r = 0; r < 2; r++) begin : g_line
    localparam int WEN_TAP = (r == 0) ? R2_WEN_TAP : R4_WEN_TAP;
    localparam int EN_TAP  = (r == 0) ? R2_EN_TAP : R4_EN_TAP;
    localparam int LEN     = ((WEN_TAP > EN_TAP) ? WEN_TAP : EN_TAP) + 1;

    logic [LEN-1:0] hist;
    logic           shift_en;

    assign shift_en = (r == 0) ? ~sel_radix4 : sel_radix4;

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        hist <= '0;
      end else if (shift_en) begin
        hist <= {hist[LEN-2:0], read_active};
      end
    end

    assign line_wen[r] = hist[WEN_TAP];
    assign line_en[r]  = hist[EN_TAP];
  end

  // plain one cycle enable
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      en_direct <= 1'b0;
    end else begin
      en_direct <= read_active;
    end
  end

  // write strobe from the line of the current radix
  assign wen = line_wen[sel_radix4];

  // in the done state, hold enable until the pipeline empties
  assign en = draining ? line_en[sel_radix4] : en_direct;

endmodule

//--- design/ntt_addr_gen.sv
module ntt_addr_gen (
  input  logic                clk,
  input  logic                rst,
  input  ntt_pkg::run_mode_u  run_mode,
  output logic                sel_radix4,
  output logic                sel_inverse,
  output ntt_pkg::step_idx_t  i,
  output ntt_pkg::step_idx_t  k,
  output ntt_pkg::step_idx_t  j,
  output ntt_pkg::stage_t     p,
  output ntt_pkg::done_code_t done_flag,
  output logic                wen,
  output logic                ren,
  output logic                en
);

  // control to counters
  logic run_r2;
  logic run_r4;
  logic inverse;
  // counters back to control
  logic r2_last;
  logic r4_last;
  // done state flag for the enable mux
  logic draining;

  ntt_ctrl ntt_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .run_mode    (run_mode),
    .r2_last     (r2_last),
    .r4_last     (r4_last),
    .run_r2      (run_r2),
    .run_r4      (run_r4),
    .inverse     (inverse),
    .draining    (draining),
    .sel_radix4  (sel_radix4),
    .sel_inverse (sel_inverse),
    .ren         (ren),
    .done_flag   (done_flag)
  );

  radix2_index_counter radix2_index_counter_i (
    .clk     (clk),
    .rst     (rst),
    .run_r2  (run_r2),
    .i       (i),
    .r2_last (r2_last)
  );

  radix4_index_counter radix4_index_counter_i (
    .clk     (clk),
    .rst     (rst),
    .run_r4  (run_r4),
    .inverse (inverse),
    .p       (p),
    .k       (k),
    .j       (j),
    .r4_last (r4_last)
  );

  // ren doubles as the read activity level
  butterfly_enable_delay butterfly_enable_delay_i (
    .clk         (clk),
    .rst         (rst),
    .read_active (ren),
    .sel_radix4  (sel_radix4),
    .draining    (draining),
    .wen         (wen),
    .en          (en)
  );

endmodule

//--- design/ntt_config.svh
`ifndef NTT_CONFIG_SVH
`define NTT_CONFIG_SVH

// kyber point layout
// butterfly steps in one stage, same for radix-2 and radix-4
`define NTT_STEPS 32

// radix-4 stage count, p runs 0..2
`define NTT_R4_STAGES 3

// read strobe to write strobe, radix-2 butterfly pipeline
`define NTT_R2_WEN_DELAY 11
// same on the longer radix-4 pipeline
`define NTT_R4_WEN_DELAY 13

// enable hold after ren falls, radix-2
`define NTT_R2_DRAIN 10
// enable hold after ren falls, radix-4
`define NTT_R4_DRAIN 12

`endif

//--- design/ntt_ctrl.sv
module ntt_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  ntt_pkg::run_mode_u   run_mode,
  input  logic                 r2_last,
  input  logic                 r4_last,
  output logic                 run_r2,
  output logic                 run_r4,
  output logic                 inverse,
  output logic                 draining,
  output logic                 sel_radix4,
  output logic                 sel_inverse,
  output logic                 ren,
  output ntt_pkg::done_code_t  done_flag
);
  import ntt_pkg::*;

  // registered host mode
  run_mode_u mode_q;
  // run flag honoured only without drain
  logic      run_ok;

  // mode register, one cycle behind the host
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mode_q.raw <= MODE_IDLE;
    end else begin
      mode_q.raw <= run_mode.raw;
    end
  end

  // a word with both active and drain set counts as no run
  assign run_ok = mode_q.f.active & ~mode_q.f.drain;

  // counter run levels, straight from the mode flags
  assign run_r2   = run_ok & ~mode_q.f.radix4;
  assign run_r4   = run_ok & mode_q.f.radix4;
  // direction for the radix-4 stage walk
  assign inverse  = mode_q.f.inverse;
  // done state, enable follows the drain line
  assign draining = mode_q.f.drain;

  // datapath selects and read strobe
  // one more register, so two cycles after the host word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sel_radix4  <= 1'b0;
      sel_inverse <= 1'b0;
      ren         <= 1'b0;
    end else begin
      // selects stay set through the done state
      sel_radix4  <= mode_q.f.radix4;
      sel_inverse <= mode_q.f.inverse;
      ren         <= run_ok;
    end
  end

  // done code on the final step only
  // bound test sits in the counters, here just the mode
  always_comb begin
    done_flag = DONE_NONE;
    if (run_r2 && r2_last) begin
      // radix-2 pass finished
      if (mode_q.f.inverse) begin
        done_flag = DONE_R2_INTT;
      end else begin
        done_flag = DONE_R2_NTT;
      end
    end else if (run_r4 && r4_last) begin
      // last butterfly of the end stage
      if (mode_q.f.inverse) begin
        done_flag = DONE_R4_INTT;
      end else begin
        done_flag = DONE_R4_NTT;
      end
    end
  end

endmodule

//--- design/ntt_pkg.sv
package ntt_pkg;

  // butterfly index, shared by i, j and k
  typedef logic [4:0] step_idx_t;

  // radix-4 stage number p
  typedef logic [1:0] stage_t;

  // run mode word, read raw for loading and by flag for decode
  // idle is all zero, run sets active, done clears active and sets drain
  typedef union packed {
    logic [3:0] raw;
    struct packed {
      logic drain;
      logic inverse;
      logic radix4;
      logic active;
    } f;
  } run_mode_u;

  // host mode codes
  localparam logic [3:0] MODE_IDLE         = 4'b0000;
  localparam logic [3:0] MODE_R2_NTT       = 4'b0001;
  localparam logic [3:0] MODE_R4_NTT       = 4'b0011;
  localparam logic [3:0] MODE_R2_INTT      = 4'b0101;
  localparam logic [3:0] MODE_R4_INTT      = 4'b0111;
  localparam logic [3:0] MODE_DONE_R2_NTT  = 4'b1000;
  localparam logic [3:0] MODE_DONE_R4_NTT  = 4'b1010;
  localparam logic [3:0] MODE_DONE_R2_INTT = 4'b1100;
  localparam logic [3:0] MODE_DONE_R4_INTT = 4'b1110;

  // one-cycle done marker on the last step
  typedef logic [2:0] done_code_t;

  localparam done_code_t DONE_NONE    = 3'd0;
  localparam done_code_t DONE_R2_NTT  = 3'd1;
  localparam done_code_t DONE_R4_NTT  = 3'd2;
  localparam done_code_t DONE_R4_INTT = 3'd3;
  localparam done_code_t DONE_R2_INTT = 3'd4;

endpackage

//--- design/radix2_index_counter.sv
`include "ntt_config.svh"

module radix2_index_counter (
  input  logic                clk,
  input  logic                rst,
  input  logic                run_r2,
  output ntt_pkg::step_idx_t  i,
  output logic                r2_last
);
  import ntt_pkg::*;

  // final butterfly of the single pass
  localparam step_idx_t I_LAST = step_idx_t'(`NTT_STEPS - 1);

  // one step per cycle during the run
  // cleared whenever the run level is low
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      i <= '0;
    end else if (run_r2) begin
      // 5 bits, wraps back to 0 after 31
      i <= i + 1'b1;
    end else begin
      i <= '0;
    end
  end

  // last step flag, mode check lives in the control
  assign r2_last = (i == I_LAST);

endmodule

//--- design/radix4_index_counter.sv
`include "ntt_config.svh"

module radix4_index_counter (
  input  logic                clk,
  input  logic                rst,
  input  logic                run_r4,
  input  logic                inverse,
  output ntt_pkg::stage_t     p,
  output ntt_pkg::step_idx_t  k,
  output ntt_pkg::step_idx_t  j,
  output logic                r4_last
);
  import ntt_pkg::*;

  // highest stage, p = 2 for kyber
  localparam stage_t P_TOP = stage_t'(`NTT_R4_STAGES - 1);

  // stages done so far in this run, 0 at the start stage
  stage_t     st;
  // shift amount 2*p
  logic [2:0] shamt;
  // butterflies per group and groups per stage
  logic [5:0] j_span;
  logic [5:0] k_span;
  step_idx_t  j_max;
  step_idx_t  k_max;
  // wrap points of each loop level
  logic       j_wrap;
  logic       k_wrap;
  logic       p_end;

  // ntt walks 2,1,0 and intt walks 0,1,2
  assign p = inverse ? st : P_TOP - st;

  // 4^p butterflies per group
  assign shamt  = {p, 1'b0};
  assign j_span = 6'd1 << shamt;
  // 32 / 4^p groups
  assign k_span = 6'(`NTT_STEPS) >> shamt;
  assign j_max  = step_idx_t'(j_span - 6'd1);
  assign k_max  = step_idx_t'(k_span - 6'd1);

  assign j_wrap = (j == j_max);
  assign k_wrap = (k == k_max);
  // end stage reached after the last stage step
  assign p_end  = (st == P_TOP);

  // j fastest, then k, then p
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      st <= '0;
      k  <= '0;
      j  <= '0;
    end else if (!run_r4) begin
      // park at the start stage between runs
      st <= '0;
      k  <= '0;
      j  <= '0;
    end else if (!j_wrap) begin
      j <= j + 1'b1;
    end else begin
      j <= '0;
      if (!k_wrap) begin
        k <= k + 1'b1;
      end else begin
        k <= '0;
        // stage done, step p or restart the walk
        if (p_end) begin
          st <= '0;
        end else begin
          st <= st + 1'b1;
        end
      end
    end
  end

  // very last butterfly of the end stage
  assign r4_last = j_wrap & k_wrap & p_end;

endmodule

//--- files.f
+incdir+design
design/ntt_pkg.sv
design/ntt_ctrl.sv
design/radix2_index_counter.sv
design/radix4_index_counter.sv
design/butterfly_enable_delay.sv
design/ntt_addr_gen.sv
tests/ntt_addr_gen_properties.sv
tests/ntt_addr_gen_tb.sv

//--- tests/ntt_addr_gen_properties.sv
`include "ntt_config.svh"

module ntt_addr_gen_properties (
  input logic                clk,
  input logic                rst,
  input logic                ren,
  input logic                wen,
  input ntt_pkg::done_code_t done_flag,
  input ntt_pkg::stage_t     p,
  output int                 fail_count
);
  import ntt_pkg::*;

  // longer pipeline sets the history depth
  localparam int HIST_LEN = `NTT_R4_WEN_DELAY;
  localparam stage_t P_MAX = stage_t'(`NTT_R4_STAGES - 1);

  // past read strobes still in flight
  logic [HIST_LEN-1:0] ren_hist;
  // failures per property
  int wen_fails = 0;
  int done_fails = 0;
  int stage_fails = 0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ren_hist <= '0;
    end else begin
      ren_hist <= {ren_hist[HIST_LEN-2:0], ren};
    end
  end

  assign fail_count = wen_fails + done_fails + stage_fails;

  // no write without a read now or in the pipeline
  assert property (@(posedge clk) disable iff (rst) wen |-> (ren || (|ren_hist)))
    else begin
      $error("wen high with no read strobe in the pipeline history");
      wen_fails++;
    end

  // done marker is a single pulse
  assert property (@(posedge clk) disable iff (rst)
                   (done_flag != DONE_NONE) |=> (done_flag == DONE_NONE))
    else begin
      $error("done_flag held longer than one cycle");
      done_fails++;
    end

  // stage number stays in range
  assert property (@(posedge clk) disable iff (rst) p <= P_MAX)
    else begin
      $error("stage p above the last radix-4 stage");
      stage_fails++;
    end

endmodule

bind ntt_addr_gen ntt_addr_gen_properties ntt_addr_gen_properties_i (
  .clk        (clk),
  .rst        (rst),
  .ren        (ren),
  .wen        (wen),
  .done_flag  (done_flag),
  .p          (p),
  .fail_count ()
);

//--- tests/ntt_addr_gen_tb.sv
`include "ntt_config.svh"

module ntt_addr_gen_tb;
  import ntt_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  // done code hold, longer than the longest drain
  localparam int DONE_WINDOW  = 20;
  // idle gap between runs, 3..8 cycles
  localparam int MIN_GAP      = 3;
  localparam int MAX_GAP      = 8;
  localparam int N_TESTS      = 5;
  localparam int R2_STEPS     = `NTT_STEPS;
  localparam int R4_STEPS     = `NTT_STEPS * `NTT_R4_STAGES;

  // one row per run: codes, length and expected outputs
  typedef struct packed {
    logic [3:0] run_code;
    logic [3:0] done_code;
    logic [7:0] steps;
    done_code_t exp_done;
    logic       exp_sel_r4;
    logic       exp_sel_inv;
    logic [4:0] wen_delay;
    logic [4:0] drain;
  } entry_t;

  logic       clk;
  logic       rst;
  run_mode_u  run_mode;
  logic       sel_radix4;
  logic       sel_inverse;
  step_idx_t  i;
  step_idx_t  k;
  step_idx_t  j;
  stage_t     p;
  done_code_t done_flag;
  logic       wen;
  logic       ren;
  logic       en;

  entry_t      table_q [N_TESTS];
  int          errors;
  int          checks;
  logic [31:0] rnd_state;
  // radix-4 model sequence for the current run
  stage_t      exp_p [$];
  step_idx_t   exp_k [$];
  step_idx_t   exp_j [$];

  ntt_addr_gen ntt_addr_gen_i (
    .clk         (clk),
    .rst         (rst),
    .run_mode    (run_mode),
    .sel_radix4  (sel_radix4),
    .sel_inverse (sel_inverse),
    .i           (i),
    .k           (k),
    .j           (j),
    .p           (p),
    .done_flag   (done_flag),
    .wen         (wen),
    .ren         (ren),
    .en          (en)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic bit_check(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic index_check(input string name, input step_idx_t exp, input step_idx_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic stage_check(input string name, input stage_t exp, input stage_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic done_check(input string name, input done_code_t exp, input done_code_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic fill_table();
    table_q[0] = '{MODE_R2_NTT, MODE_DONE_R2_NTT, 8'(R2_STEPS), DONE_R2_NTT,
                   1'b0, 1'b0, 5'(`NTT_R2_WEN_DELAY), 5'(`NTT_R2_DRAIN)};
    table_q[1] = '{MODE_R4_NTT, MODE_DONE_R4_NTT, 8'(R4_STEPS), DONE_R4_NTT,
                   1'b1, 1'b0, 5'(`NTT_R4_WEN_DELAY), 5'(`NTT_R4_DRAIN)};
    table_q[2] = '{MODE_R4_INTT, MODE_DONE_R4_INTT, 8'(R4_STEPS), DONE_R4_INTT,
                   1'b1, 1'b1, 5'(`NTT_R4_WEN_DELAY), 5'(`NTT_R4_DRAIN)};
    table_q[3] = '{MODE_R2_INTT, MODE_DONE_R2_INTT, 8'(R2_STEPS), DONE_R2_INTT,
                   1'b0, 1'b1, 5'(`NTT_R2_WEN_DELAY), 5'(`NTT_R2_DRAIN)};
    table_q[4] = '{MODE_R4_NTT, MODE_DONE_R4_NTT, 8'(R4_STEPS), DONE_R4_NTT,
                   1'b1, 1'b0, 5'(`NTT_R4_WEN_DELAY), 5'(`NTT_R4_DRAIN)};
  endtask

  // model walk, stage order by direction, j inside k inside p
  task automatic fill_r4_sequence(input logic inv);
    int pp;
    exp_p.delete();
    exp_k.delete();
    exp_j.delete();
    for (int st = 0; st < `NTT_R4_STAGES; st++) begin
      pp = inv ? st : `NTT_R4_STAGES - 1 - st;
      for (int kk = 0; kk < (`NTT_STEPS >> (2 * pp)); kk++) begin
        for (int jj = 0; jj < (1 << (2 * pp)); jj++) begin
          exp_p.push_back(stage_t'(pp));
          exp_k.push_back(step_idx_t'(kk));
          exp_j.push_back(step_idx_t'(jj));
        end
      end
    end
  endtask

  task automatic check_reset_state();
    bit_check("ren", 1'b0, ren);
    bit_check("wen", 1'b0, wen);
    bit_check("en", 1'b0, en);
    bit_check("sel_radix4", 1'b0, sel_radix4);
    bit_check("sel_inverse", 1'b0, sel_inverse);
    done_check("done_flag", DONE_NONE, done_flag);
  endtask

  // gap, run, done window, back to idle
  task automatic apply_entry(input int n);
    entry_t e;
    int     gap;
    int     c0;
    int     e0;
    e = table_q[n];
    c0 = checks;
    e0 = errors;
    rnd_state = xorshift32(rnd_state);
    gap = MIN_GAP + int'(rnd_state % (MAX_GAP - MIN_GAP + 1));
    if (e.exp_sel_r4) begin
      fill_r4_sequence(e.exp_sel_inv);
    end
    run_mode.raw = MODE_IDLE;
    for (int g = 0; g < gap; g++) begin
      @(negedge clk);
      bit_check("ren", 1'b0, ren);
      done_check("done_flag", DONE_NONE, done_flag);
    end
    run_mode.raw = e.run_code;
    for (int s = 0; s < e.steps; s++) begin
      @(negedge clk);
      done_check("done_flag", (s == e.steps - 1) ? e.exp_done : DONE_NONE, done_flag);
      // ren two cycles after the code, wen a pipeline later
      bit_check("ren", s >= 1, ren);
      bit_check("wen", s >= 1 + e.wen_delay, wen);
      bit_check("en", s >= 2, en);
      // selects two cycles after the code, still idle before
      bit_check("sel_radix4", (s >= 1) ? e.exp_sel_r4 : 1'b0, sel_radix4);
      bit_check("sel_inverse", (s >= 1) ? e.exp_sel_inv : 1'b0, sel_inverse);
      if (e.exp_sel_r4) begin
        stage_check("p", exp_p[s], p);
        index_check("k", exp_k[s], k);
        index_check("j", exp_j[s], j);
        index_check("i", 5'd0, i);
      end else begin
        index_check("i", step_idx_t'(s), i);
      end
    end
    run_mode.raw = e.done_code;
    for (int t = 1; t <= DONE_WINDOW; t++) begin
      @(negedge clk);
      done_check("done_flag", DONE_NONE, done_flag);
      // last read at t=1, falls at t=2
      bit_check("ren", t < 2, ren);
      bit_check("wen", t <= 1 + e.wen_delay, wen);
      // direct enable covers t=2, drain holds it that many more
      bit_check("en", t <= 2 + e.drain, en);
      bit_check("sel_radix4", e.exp_sel_r4, sel_radix4);
      bit_check("sel_inverse", e.exp_sel_inv, sel_inverse);
    end
    run_mode.raw = MODE_IDLE;
    $display("test %0d mode %04b: %0d checks, %0d errors", n, e.run_code,
             checks - c0, errors - e0);
  endtask

  initial begin : main
    int assert_fails;
    clk = 1'b0;
    rst = 1'b1;
    run_mode.raw = MODE_IDLE;
    errors = 0;
    checks = 0;
    rnd_state = 32'h92b4;
    fill_table();
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      check_reset_state();
    end
    rst = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_reset_state();
    end
    $display("test reset: %0d checks, %0d errors", checks, errors);
    for (int n = 0; n < N_TESTS; n++) begin
      apply_entry(n);
    end
    assert_fails = ntt_addr_gen_i.ntt_addr_gen_properties_i.fail_count;
    errors += assert_fails;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             N_TESTS + 1, checks, errors, assert_fails);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // limit from the table length, doubled for margin
  initial begin : watchdog
    longint limit;
    #1;
    limit = RESET_CYCLES + 2;
    for (int n = 0; n < N_TESTS; n++) begin
      limit += table_q[n].steps + DONE_WINDOW + MAX_GAP;
    end
    limit = limit * 2 * CLK_PERIOD;
    #(limit);
    $display("timeout: sequencer tests did not finish within %0d time units", limit);
    $display("Done: errors found");
    $finish;
  end

endmodule
